// File: Makefile
# Verilator build and run for the writeback back end

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_wb_top
RTL_TOP   ?= wb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

SRCS := $(shell grep -v '^+' $(FILELIST)) verilog/wb_cfg.svh
SIM  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation passed, see $(LOG)"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_wb_top.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module tb_wb_top;

  import wb_pkg::*;

  localparam int CLK_PERIOD       = 40;
  localparam int DRIVE_DELAY      = 2;
  localparam int CHECK_DELAY      = 10;
  localparam int RESET_CYCLES     = 16;
  localparam int N_INSTR          = 400;
  localparam int MAX_INSTR_CYCLES = 7;   // idu, gap 2, exu, gap 2, lsu
  localparam int TIMEOUT_CYCLES   = RESET_CYCLES + N_INSTR * MAX_INSTR_CYCLES + 200;

  logic        clk;
  logic        reset;
  idu_fields_t idu;
  logic        idu_valid;
  exu_fields_t exu;
  logic        exu_valid;
  word_t       lsu_res;
  logic        lsu_valid;
  logic        wbu_ready;
  gpr_wr_t     gpr_wr;
  csr_wr_t     csr_wr;
  reg_id_t     rs1id;
  reg_id_t     rs2id;
  word_t       rs1;
  word_t       rs2;
  csr_id_t     csr_rid;
  word_t       csr_rdata;

  logic [31:0] lcg_state;
  idu_fields_t m_idu;                    // model of the captured fields
  exu_fields_t m_exu;
  word_t       m_regs [`WB_REG_NUM];
  word_t       m_mstatus;
  word_t       m_mtvec;
  word_t       m_mepc;
  word_t       m_mcause;
  word_t       m_mcycle;
  word_t       m_minstret;
  logic        m_ready;
  int          cycles;

  wb_top i_wb_top (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_idu       (idu),
    .i_idu_valid (idu_valid),
    .i_exu       (exu),
    .i_exu_valid (exu_valid),
    .i_lsu_res   (lsu_res),
    .i_lsu_valid (lsu_valid),
    .o_wbu_ready (wbu_ready),
    .o_gpr_wr    (gpr_wr),
    .o_csr_wr    (csr_wr),
    .i_rs1id     (rs1id),
    .i_rs2id     (rs2id),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .i_csr_rid   (csr_rid),
    .o_csr_rdata (csr_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n;           // upper bits since the low ones are weak
  endfunction

  function automatic csr_id_t csr_by_index(input int i);
    case (i)
      0: return `WB_CSR_MSTATUS;
      1: return `WB_CSR_MTVEC;
      2: return `WB_CSR_MEPC;
      3: return `WB_CSR_MCAUSE;
      4: return `WB_CSR_MCYCLE;
      5: return `WB_CSR_MINSTRET;
      default: return 12'h340;           // mscratch is not implemented
    endcase
  endfunction

  function automatic csr_id_t pick_csr_id();
    int          sel;
    logic [31:0] r;
    sel = rand_below(8);
    r   = next_rand();
    if (sel == 7) begin
      return r[31:20];                   // any address
    end
    return csr_by_index(sel);
  endfunction

  function automatic word_t model_csr_read(input csr_id_t id);
    case (id)
      `WB_CSR_MSTATUS:  return m_mstatus;
      `WB_CSR_MTVEC:    return m_mtvec;
      `WB_CSR_MEPC:     return m_mepc;
      `WB_CSR_MCAUSE:   return m_mcause;
      `WB_CSR_MCYCLE:   return m_mcycle;
      `WB_CSR_MINSTRET: return m_minstret;
      default:          return '0;
    endcase
  endfunction

  function automatic gpr_wr_t expected_gpr_wr();
    gpr_wr_t w;
    w.en   = m_idu.rdwen & lsu_valid;
    w.id   = m_idu.rdid;
    w.data = m_idu.ld_en ? lsu_res : m_exu.exu_res;
    return w;
  endfunction

  function automatic csr_wr_t expected_csr_wr();
    csr_wr_t w;
    w.en   = m_idu.csrdwen & lsu_valid;
    w.id   = m_idu.csrdid;
    w.data = m_exu.csrd;
    return w;
  endfunction

  task automatic report_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_gpr_wr(input gpr_wr_t exp, input gpr_wr_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: o_gpr_wr (en id data) expected %b %0d %h, actual %b %0d %h",
               $time, exp.en, exp.id, exp.data, act.en, act.id, act.data);
      report_failure();
    end
  endtask

  task automatic check_csr_wr(input csr_wr_t exp, input csr_wr_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: o_csr_wr (en id data) expected %b %h %h, actual %b %h %h",
               $time, exp.en, exp.id, exp.data, act.en, act.id, act.data);
      report_failure();
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
      report_failure();
    end
  endtask

  // state change of the model at one rising edge
  task automatic update_model();
    gpr_wr_t gw;
    csr_wr_t cw;
    gw = expected_gpr_wr();
    cw = expected_csr_wr();
    if (gw.en && gw.id != '0) begin
      m_regs[gw.id] = gw.data;
    end
    if (cw.en) begin
      case (cw.id)
        `WB_CSR_MSTATUS: m_mstatus = cw.data & `WB_MSTATUS_WMASK;
        `WB_CSR_MTVEC:   m_mtvec   = cw.data;
        `WB_CSR_MEPC:    m_mepc    = cw.data & 32'hFFFF_FFFC;
        `WB_CSR_MCAUSE:  m_mcause  = cw.data;
        default: ;
      endcase
    end
    if (cw.en && cw.id == `WB_CSR_MCYCLE) begin
      m_mcycle = cw.data;                // write beats the increment
    end else begin
      m_mcycle = m_mcycle + 32'd1;
    end
    if (cw.en && cw.id == `WB_CSR_MINSTRET) begin
      m_minstret = cw.data;
    end else if (lsu_valid) begin
      m_minstret = m_minstret + 32'd1;
    end
    if (idu_valid) begin
      m_idu = idu;
    end
    if (exu_valid) begin
      m_exu = exu;
    end
    m_ready = lsu_valid;
  endtask

  task automatic check_outputs();
    check_bit("o_wbu_ready", m_ready, wbu_ready);
    check_gpr_wr(expected_gpr_wr(), gpr_wr);
    check_csr_wr(expected_csr_wr(), csr_wr);
    check_word("o_rs1", m_regs[rs1id], rs1);
    check_word("o_rs2", m_regs[rs2id], rs2);
    check_word("o_csr_rdata", model_csr_read(csr_rid), csr_rdata);
  endtask

  // strobes for this cycle are already driven by the caller
  task automatic run_cycle();
    rs1id = reg_id_t'(rand_below(32));
    if (rand_below(2) == 0) begin
      rs2id = m_idu.rdid;                // favor the last destination
    end else begin
      rs2id = reg_id_t'(rand_below(32));
    end
    csr_rid = pick_csr_id();
    #(CHECK_DELAY);
    check_outputs();
    @(posedge clk);
    update_model();
    #(DRIVE_DELAY);
    idu_valid = 1'b0;
    exu_valid = 1'b0;
    lsu_valid = 1'b0;
  endtask

  task automatic run_gap();
    int gap;
    gap = rand_below(3);
    repeat (gap) begin
      run_cycle();
    end
  endtask

  task automatic run_instr();
    idu.ld_en   = rand_below(2) == 1;
    idu.rdwen   = rand_below(4) != 0;
    idu.rdid    = reg_id_t'(rand_below(32));
    idu.csrdwen = rand_below(2) == 1;
    idu.csrdid  = pick_csr_id();
    idu_valid   = 1'b1;
    run_cycle();
    run_gap();
    exu.exu_res = next_rand();
    exu.csrd    = next_rand();
    exu_valid   = 1'b1;
    run_cycle();
    run_gap();
    lsu_res   = next_rand();
    lsu_valid = 1'b1;
    run_cycle();
  endtask

  // sweep every read index in the first cycle out of reset
  task automatic check_reset_state();
    check_bit("o_wbu_ready", 1'b1, wbu_ready);
    check_bit("o_gpr_wr.en", 1'b0, gpr_wr.en);
    check_bit("o_csr_wr.en", 1'b0, csr_wr.en);
    for (int i = 0; i < 16; i++) begin
      rs1id = reg_id_t'(i);
      rs2id = reg_id_t'(i + 16);
      #1;
      check_word("o_rs1", '0, rs1);
      check_word("o_rs2", '0, rs2);
    end
    for (int i = 0; i < 7; i++) begin
      csr_rid = csr_by_index(i);
      #1;
      check_word("o_csr_rdata", '0, csr_rdata);
    end
    @(posedge clk);
    update_model();
    #(DRIVE_DELAY);
  endtask

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        report_failure();
      end
    end
  end

  initial begin
    lcg_state = 32'd1249;
    reset     = 1'b1;
    idu       = '0;
    idu_valid = 1'b0;
    exu       = '0;
    exu_valid = 1'b0;
    lsu_res   = '0;
    lsu_valid = 1'b0;
    rs1id     = '0;
    rs2id     = '0;
    csr_rid   = '0;
    m_idu     = '0;
    m_exu     = '0;
    for (int i = 0; i < `WB_REG_NUM; i++) begin
      m_regs[i] = '0;
    end
    m_mstatus  = '0;
    m_mtvec    = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mcycle   = '0;
    m_minstret = '0;
    m_ready    = 1'b1;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
    end
    #(DRIVE_DELAY);
    reset = 1'b0;
    check_reset_state();
    for (int n = 0; n < N_INSTR; n++) begin
      run_instr();
    end
    run_cycle();                         // last commit visible on the read ports
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog/csr_file.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module csr_file (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  wb_pkg::csr_wr_t          i_wr,
  input  logic                     i_retire,
  input  logic [`WB_CSR_ADDRW-1:0] i_rid,
  output logic [`WB_CPU_WIDTH-1:0] o_rdata
);

  import wb_pkg::*;

  word_t mstatus;
  word_t mtvec;
  word_t mepc;
  word_t mcause;
  word_t mcycle;
  word_t minstret;
  logic  wr_mcycle;
  logic  wr_minstret;

  assign wr_mcycle   = i_wr.en && (i_wr.id == `WB_CSR_MCYCLE);
  assign wr_minstret = i_wr.en && (i_wr.id == `WB_CSR_MINSTRET);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_wr.en) begin
      case (i_wr.id)
        `WB_CSR_MSTATUS: mstatus <= i_wr.data & `WB_MSTATUS_WMASK;
        `WB_CSR_MTVEC:   mtvec   <= i_wr.data;
        `WB_CSR_MEPC:    mepc    <= {i_wr.data[`WB_CPU_WIDTH-1:2], 2'b00}; // ialign 32
        `WB_CSR_MCAUSE:  mcause  <= i_wr.data;
        default: ;                       // unimplemented writes dropped
      endcase
    end
  end

  // free running counter where a write has priority
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mcycle <= '0;
    end else if (wr_mcycle) begin
      mcycle <= i_wr.data;
    end else begin
      mcycle <= mcycle + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      minstret <= '0;
    end else if (wr_minstret) begin
      minstret <= i_wr.data;
    end else if (i_retire) begin
      minstret <= minstret + 1'b1;
    end
  end

  always_comb begin
    case (i_rid)
      `WB_CSR_MSTATUS:  o_rdata = mstatus;
      `WB_CSR_MTVEC:    o_rdata = mtvec;
      `WB_CSR_MEPC:     o_rdata = mepc;
      `WB_CSR_MCAUSE:   o_rdata = mcause;
      `WB_CSR_MCYCLE:   o_rdata = mcycle;
      `WB_CSR_MINSTRET: o_rdata = minstret;
      default:          o_rdata = '0;
    endcase
  end

  a_mstatus_mask : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (i_wr.en && (i_wr.id == `WB_CSR_MSTATUS)) |=>
      ((mstatus & ~`WB_MSTATUS_WMASK) == ($past(mstatus) & ~`WB_MSTATUS_WMASK))
  ) else $error("mstatus write touched a read-only bit");

endmodule

// File: verilog/gpr_file.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module gpr_file (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  wb_pkg::gpr_wr_t          i_wr,
  input  logic [`WB_REG_ADDRW-1:0] i_rs1id,
  input  logic [`WB_REG_ADDRW-1:0] i_rs2id,
  output logic [`WB_CPU_WIDTH-1:0] o_rs1,
  output logic [`WB_CPU_WIDTH-1:0] o_rs2
);

  import wb_pkg::*;

  word_t regs [1:`WB_REG_NUM-1];         // no storage for x0
  logic  wr_ok;

  assign wr_ok = i_wr.en && (i_wr.id != '0);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 1; i < `WB_REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[i_wr.id] <= i_wr.data;
    end
  end

  // async read with x0 hardwired
  always_comb begin
    if (i_rs1id == '0) begin
      o_rs1 = '0;
    end else begin
      o_rs1 = regs[i_rs1id];
    end
  end

  always_comb begin
    if (i_rs2id == '0) begin
      o_rs2 = '0;
    end else begin
      o_rs2 = regs[i_rs2id];
    end
  end

  a_x0_zero : assert property (
    @(posedge i_clk) disable iff (i_reset)
    ((i_rs1id == '0) |-> (o_rs1 == '0)) and ((i_rs2id == '0) |-> (o_rs2 == '0))
  ) else $error("x0 read nonzero");

endmodule

// File: verilog/wb_cfg.svh
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

`define WB_CPU_WIDTH 32                  // data word
`define WB_REG_ADDRW 5                   // gpr index
`define WB_REG_NUM   32                  // x0 included
`define WB_CSR_ADDRW 12

`define WB_CSR_MSTATUS  12'h300
`define WB_CSR_MTVEC    12'h305
`define WB_CSR_MEPC     12'h341
`define WB_CSR_MCAUSE   12'h342
`define WB_CSR_MCYCLE   12'hB00          // low word only
`define WB_CSR_MINSTRET 12'hB02          // low word only

// MPP[12:11], MPIE[7] and MIE[3]
`define WB_MSTATUS_WMASK 32'h0000_1888

`endif

// File: verilog/wb_pkg.sv
`include "wb_cfg.svh"

package wb_pkg;

  typedef logic [`WB_CPU_WIDTH-1:0] word_t;
  typedef logic [`WB_REG_ADDRW-1:0] reg_id_t;
  typedef logic [`WB_CSR_ADDRW-1:0] csr_id_t;

  // fields latched on the idu strobe
  typedef struct packed {
    logic    ld_en;                      // rd comes from lsu
    logic    rdwen;
    reg_id_t rdid;
    logic    csrdwen;
    csr_id_t csrdid;
  } idu_fields_t;

  // fields latched on the exu strobe
  typedef struct packed {
    word_t exu_res;
    word_t csrd;                         // new csr value
  } exu_fields_t;

  typedef struct packed {
    logic    en;
    reg_id_t id;
    word_t   data;
  } gpr_wr_t;

  typedef struct packed {
    logic    en;
    csr_id_t id;
    word_t   data;
  } csr_wr_t;

endpackage

// File: verilog/wb_top.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module wb_top (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  wb_pkg::idu_fields_t      i_idu,
  input  logic                     i_idu_valid,
  input  wb_pkg::exu_fields_t      i_exu,
  input  logic                     i_exu_valid,
  input  logic [`WB_CPU_WIDTH-1:0] i_lsu_res,
  input  logic                     i_lsu_valid,
  output logic                     o_wbu_ready,
  output wb_pkg::gpr_wr_t          o_gpr_wr,    // commit ports for observation
  output wb_pkg::csr_wr_t          o_csr_wr,
  input  logic [`WB_REG_ADDRW-1:0] i_rs1id,
  input  logic [`WB_REG_ADDRW-1:0] i_rs2id,
  output logic [`WB_CPU_WIDTH-1:0] o_rs1,
  output logic [`WB_CPU_WIDTH-1:0] o_rs2,
  input  logic [`WB_CSR_ADDRW-1:0] i_csr_rid,
  output logic [`WB_CPU_WIDTH-1:0] o_csr_rdata
);

  wbu u_wbu (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_idu       (i_idu),
    .i_idu_valid (i_idu_valid),
    .i_exu       (i_exu),
    .i_exu_valid (i_exu_valid),
    .i_lsu_res   (i_lsu_res),
    .i_lsu_valid (i_lsu_valid),
    .o_gpr_wr    (o_gpr_wr),
    .o_csr_wr    (o_csr_wr),
    .o_wbu_ready (o_wbu_ready)
  );

  gpr_file u_gpr_file (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_wr    (o_gpr_wr),
    .i_rs1id (i_rs1id),
    .i_rs2id (i_rs2id),
    .o_rs1   (o_rs1),
    .o_rs2   (o_rs2)
  );

  csr_file u_csr_file (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_wr     (o_csr_wr),
    .i_retire (i_lsu_valid),             // one retire per commit
    .i_rid    (i_csr_rid),
    .o_rdata  (o_csr_rdata)
  );

endmodule

// File: verilog/wbu.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module wbu (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  wb_pkg::idu_fields_t      i_idu,
  input  logic                     i_idu_valid,
  input  wb_pkg::exu_fields_t      i_exu,
  input  logic                     i_exu_valid,
  input  logic [`WB_CPU_WIDTH-1:0] i_lsu_res,
  input  logic                     i_lsu_valid,
  output wb_pkg::gpr_wr_t          o_gpr_wr,
  output wb_pkg::csr_wr_t          o_csr_wr,
  output logic                     o_wbu_ready
);

  import wb_pkg::*;

  idu_fields_t idu_q;
  exu_fields_t exu_q;
  logic        ready_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      idu_q <= '0;
    end else if (i_idu_valid) begin
      idu_q <= i_idu;                    // a new strobe overwrites
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      exu_q <= '0;
    end else if (i_exu_valid) begin
      exu_q <= i_exu;
    end
  end

  // ready trails the lsu strobe by a cycle
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ready_q <= 1'b1;
    end else begin
      ready_q <= i_lsu_valid;
    end
  end

  assign o_wbu_ready = ready_q;

  // commit happens in the lsu strobe cycle
  always_comb begin
    o_gpr_wr.en   = idu_q.rdwen & i_lsu_valid;
    o_gpr_wr.id   = idu_q.rdid;
    o_gpr_wr.data = idu_q.ld_en ? i_lsu_res : exu_q.exu_res;
  end

  always_comb begin
    o_csr_wr.en   = idu_q.csrdwen & i_lsu_valid;
    o_csr_wr.id   = idu_q.csrdid;
    o_csr_wr.data = exu_q.csrd;
  end

  a_idu_lsu_excl : assert property (
    @(posedge i_clk) disable iff (i_reset)
    !(i_idu_valid && i_lsu_valid)
  ) else $error("idu and lsu strobes in the same cycle");

  a_wen_needs_lsu : assert property (
    @(posedge i_clk) disable iff (i_reset)
    ($rose(o_gpr_wr.en) || $rose(o_csr_wr.en)) |-> i_lsu_valid
  ) else $error("write enable without lsu strobe");

endmodule

// File: vlog.f
+incdir+verilog
verilog/wb_pkg.sv
verilog/wbu.sv
verilog/gpr_file.sv
verilog/csr_file.sv
verilog/wb_top.sv
tb/tb_wb_top.sv
